// ==== source/conv_pkg.sv ====
`default_nettype none

package conv_pkg;

    localparam int pixel_w   = 16;
    localparam int coef_w    = 16;
    localparam int acc_w     = 48;
    localparam int addr_w    = 14;  // 128x128 output map
    localparam int wb_adr_w  = 16;
    localparam int wb_dat_w  = 32;
    localparam int reg_off_w = 4;   // Offset bits decoded in the register region

    typedef logic signed [pixel_w-1:0] pixel_t;
    typedef logic signed [coef_w-1:0]  coef_t;
    typedef logic signed [acc_w-1:0]   acc_t;
    typedef logic [addr_w-1:0]         res_addr_t;

    // Row-major 3x3 window, p0 is the top left pixel
    typedef struct packed {
        pixel_t p0, p1, p2;  // Row 0
        pixel_t p3, p4, p5;  // Row 1
        pixel_t p6, p7, p8;  // Row 2
    } window_t;

    // Coefficient kn multiplies pixel pn
    typedef struct packed {
        coef_t k0, k1, k2;
        coef_t k3, k4, k5;
        coef_t k6, k7, k8;
    } kernel_t;

    typedef struct packed {
        window_t   window;
        res_addr_t out_addr;
        logic      first;  // Start from bias instead of the stored partial sum
    } conv_job_t;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [wb_adr_w-1:0] adr;
        logic [wb_dat_w-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [wb_dat_w-1:0] dat;
        logic                ack;
    } wb_rsp_t;

    // Register offsets in region 0 (adr[15] low)
    typedef enum logic [reg_off_w-1:0] {
        reg_k0      = 4'd0,
        reg_k1      = 4'd1,
        reg_k2      = 4'd2,
        reg_k3      = 4'd3,
        reg_k4      = 4'd4,
        reg_k5      = 4'd5,
        reg_k6      = 4'd6,
        reg_k7      = 4'd7,
        reg_k8      = 4'd8,
        reg_bias_lo = 4'd9,
        reg_bias_hi = 4'd10,
        reg_status  = 4'd11
    } cfg_reg_e;

    typedef enum logic [1:0] {
        seq_idle  = 2'd0,
        seq_read  = 2'd1,
        seq_write = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire

// ==== source/mac3x3.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac3x3 (
    input  conv_pkg::window_t window,
    input  conv_pkg::kernel_t kernel,
    output conv_pkg::acc_t    dot
);
    import conv_pkg::*;

    logic signed [pixel_w+coef_w-1:0] prod [9];  // Full precision products

    acc_t s01, s23, s45, s67;
    acc_t s0123, s4567;
    acc_t s_all;

    assign prod[0] = window.p0 * kernel.k0;
    assign prod[1] = window.p1 * kernel.k1;
    assign prod[2] = window.p2 * kernel.k2;
    assign prod[3] = window.p3 * kernel.k3;
    assign prod[4] = window.p4 * kernel.k4;
    assign prod[5] = window.p5 * kernel.k5;
    assign prod[6] = window.p6 * kernel.k6;
    assign prod[7] = window.p7 * kernel.k7;
    assign prod[8] = window.p8 * kernel.k8;

    // First level, products sign-extend to 48 bits here
    assign s01 = prod[0] + prod[1];
    assign s23 = prod[2] + prod[3];
    assign s45 = prod[4] + prod[5];
    assign s67 = prod[6] + prod[7];

    assign s0123 = s01 + s23;
    assign s4567 = s45 + s67;
    assign s_all = s0123 + s4567;

    assign dot = s_all + prod[8];  // Odd ninth term joins last

endmodule

`default_nettype wire

// ==== source/dual_port_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module dual_port_ram #(
    parameter int data_w = conv_pkg::acc_w,
    parameter int addr_w = conv_pkg::addr_w
) (
    input  logic              clk,
    // Port A, read-modify-write side
    input  logic              a_en,
    input  logic              a_we,
    input  logic [addr_w-1:0] a_addr,
    input  logic [data_w-1:0] a_wdata,
    output logic [data_w-1:0] a_rdata,
    // Port B, read only
    input  logic              b_en,
    input  logic [addr_w-1:0] b_addr,
    output logic [data_w-1:0] b_rdata
);

    logic [data_w-1:0] mem [2**addr_w];

    // Read-first, old contents come out on a write
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rdata <= mem[a_addr];
            if (a_we) begin
                mem[a_addr] <= a_wdata;
            end
        end
    end

    // Same-edge collision with port A returns the old word
    always_ff @(posedge clk) begin
        if (b_en) begin
            b_rdata <= mem[b_addr];
        end
    end

endmodule

`default_nettype wire

// ==== source/accum_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module accum_seq (
    input  logic                clk,
    input  logic                arst_n,
    // Job stream
    input  logic                job_valid,
    input  conv_pkg::conv_job_t job,
    output logic                job_ready,
    // Datapath
    input  conv_pkg::acc_t      bias,
    output conv_pkg::window_t   window,
    input  conv_pkg::acc_t      dot,
    // Result RAM port A
    output logic                ram_en,
    output logic                ram_we,
    output conv_pkg::res_addr_t ram_addr,
    output conv_pkg::acc_t      ram_wdata,
    input  conv_pkg::acc_t      ram_rdata,
    output logic                busy
);
    import conv_pkg::*;

    seq_state_e state;
    conv_job_t  job_q;  // Job under processing
    acc_t       base;   // Bias or stored partial sum

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= seq_idle;
        end else begin
            case (state)
                seq_idle:  if (job_valid) state <= seq_read;
                seq_read:  state <= seq_write;
                seq_write: state <= seq_idle;
                default:   state <= seq_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (job_valid && job_ready) begin
            job_q <= job;
        end
    end

    assign job_ready = (state == seq_idle);
    assign busy      = (state != seq_idle);

    // Read in seq_read, data returns during seq_write
    assign ram_en   = (state == seq_read) || (state == seq_write);
    assign ram_we   = (state == seq_write);
    assign ram_addr = job_q.out_addr;

    assign window    = job_q.window;
    assign base      = job_q.first ? bias : ram_rdata;
    assign ram_wdata = base + dot;

endmodule

`default_nettype wire

// ==== source/wb_cfg_port.sv ====
`timescale 1ns/1ns
`default_nettype none

module wb_cfg_port (
    input  logic                clk,
    input  logic                arst_n,
    input  conv_pkg::wb_req_t   wb_req,
    output conv_pkg::wb_rsp_t   wb_rsp,
    input  logic                busy,
    output conv_pkg::kernel_t   kernel,
    output conv_pkg::acc_t      bias,
    // Result readback through RAM port B
    output logic                rd_en,
    output conv_pkg::res_addr_t rd_addr,
    input  conv_pkg::acc_t      rd_data
);
    import conv_pkg::*;

    localparam int hi_w = acc_w - wb_dat_w;  // Width of the upper result half

    coef_t [0:8]         coef_q;   // Index 0 lands on k0 (MSB)
    acc_t                bias_q;
    logic                ack_q;
    logic                pend_q;   // RAM read in flight
    logic                half_q;
    logic [wb_dat_w-1:0] dat_q;
    logic [wb_dat_w-1:0] reg_rdata;
    logic                start;
    logic                ram_region;
    logic                off_ok;
    logic                reg_wr;
    cfg_reg_e            off;

    assign ram_region = wb_req.adr[wb_adr_w-1];
    assign off_ok     = (wb_req.adr[wb_adr_w-2:reg_off_w] == '0);
    assign off        = cfg_reg_e'(wb_req.adr[reg_off_w-1:0]);

    // New request only when nothing is acked or pending
    assign start   = wb_req.cyc && wb_req.stb && !ack_q && !pend_q;
    assign rd_en   = start && ram_region && !wb_req.we;
    assign rd_addr = wb_req.adr[addr_w:1];
    assign reg_wr  = start && !ram_region && wb_req.we && off_ok;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q  <= 1'b0;
            pend_q <= 1'b0;
        end else begin
            ack_q  <= (start && !rd_en) || pend_q;
            pend_q <= rd_en;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            coef_q <= '0;
            bias_q <= '0;
        end else if (reg_wr) begin
            case (off)
                reg_k0, reg_k1, reg_k2, reg_k3, reg_k4,
                reg_k5, reg_k6, reg_k7, reg_k8: coef_q[off] <= coef_t'(wb_req.dat[coef_w-1:0]);
                reg_bias_lo: bias_q[wb_dat_w-1:0] <= wb_req.dat;
                reg_bias_hi: bias_q[acc_w-1:wb_dat_w] <= wb_req.dat[hi_w-1:0];
                default: ;  // Status and holes ignore writes
            endcase
        end
    end

    always_comb begin
        reg_rdata = '0;
        if (!ram_region && off_ok) begin
            case (off)
                reg_k0, reg_k1, reg_k2, reg_k3, reg_k4,
                reg_k5, reg_k6, reg_k7, reg_k8: reg_rdata = wb_dat_w'(coef_q[off]);
                reg_bias_lo: reg_rdata = bias_q[wb_dat_w-1:0];
                reg_bias_hi: reg_rdata = {{(wb_dat_w-hi_w){bias_q[acc_w-1]}},
                                          bias_q[acc_w-1:wb_dat_w]};
                reg_status:  reg_rdata = {{(wb_dat_w-1){1'b0}}, busy};
                default:     reg_rdata = '0;
            endcase
        end
    end

    // Response data, RAM word arrives one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            half_q <= wb_req.adr[0];
        end
        if (pend_q) begin
            dat_q <= half_q ? {{(wb_dat_w-hi_w){rd_data[acc_w-1]}}, rd_data[acc_w-1:wb_dat_w]}
                            : rd_data[wb_dat_w-1:0];
        end else if (start) begin
            dat_q <= reg_rdata;
        end
    end

    assign kernel = kernel_t'(coef_q);
    assign bias   = bias_q;
    assign wb_rsp = '{dat: dat_q, ack: ack_q};

endmodule

`default_nettype wire

// ==== source/conv_pe_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module conv_pe_top (
    input  logic                clk,
    input  logic                arst_n,
    // Job stream
    input  logic                job_valid,
    input  conv_pkg::conv_job_t job,
    output logic                job_ready,
    // Configuration and readback
    input  conv_pkg::wb_req_t   wb_req,
    output conv_pkg::wb_rsp_t   wb_rsp
);
    import conv_pkg::*;

    kernel_t   kernel;
    acc_t      bias;
    window_t   window;
    acc_t      dot;
    logic      busy;

    logic      ram_a_en;
    logic      ram_a_we;
    res_addr_t ram_a_addr;
    acc_t      ram_a_wdata;
    acc_t      ram_a_rdata;
    logic      ram_b_en;
    res_addr_t ram_b_addr;
    acc_t      ram_b_rdata;

    wb_cfg_port u_cfg (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .busy    (busy),
        .kernel  (kernel),
        .bias    (bias),
        .rd_en   (ram_b_en),
        .rd_addr (ram_b_addr),
        .rd_data (ram_b_rdata)
    );

    accum_seq u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .job_valid (job_valid),
        .job       (job),
        .job_ready (job_ready),
        .bias      (bias),
        .window    (window),
        .dot       (dot),
        .ram_en    (ram_a_en),
        .ram_we    (ram_a_we),
        .ram_addr  (ram_a_addr),
        .ram_wdata (ram_a_wdata),
        .ram_rdata (ram_a_rdata),
        .busy      (busy)
    );

    mac3x3 u_mac (
        .window (window),
        .kernel (kernel),
        .dot    (dot)
    );

    // Result memory, one word per output pixel
    dual_port_ram #(
        .data_w (acc_w),
        .addr_w (addr_w)
    ) u_ram (
        .clk     (clk),
        .a_en    (ram_a_en),
        .a_we    (ram_a_we),
        .a_addr  (ram_a_addr),
        .a_wdata (ram_a_wdata),
        .a_rdata (ram_a_rdata),
        .b_en    (ram_b_en),
        .b_addr  (ram_b_addr),
        .b_rdata (ram_b_rdata)
    );

endmodule

`default_nettype wire

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
    parameter int period_ns  = 8,
    parameter int rst_cycles = 5
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== dv/conv_pe_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module conv_pe_asserts (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 job_valid,
    input logic                 job_ready,
    input conv_pkg::wb_req_t    wb_req,
    input conv_pkg::wb_rsp_t    wb_rsp,
    input logic                 ram_we
);

    int unsigned fail_cnt = 0;  // Failed assertion count

    // Sequencer is busy for a read and a write cycle after each transfer
    a_ready_gap: assert property (@(posedge clk) disable iff (!arst_n)
        (job_valid && job_ready) |=> !job_ready ##1 !job_ready ##1 job_ready)
        else begin
            $error("job_ready not low for exactly two cycles after a transfer");
            fail_cnt++;
        end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else begin
            $error("Wishbone ack outside an active cycle");
            fail_cnt++;
        end

    a_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            $error("Wishbone ack held for more than one cycle");
            fail_cnt++;
        end

    // Write state is the second cycle after a transfer
    a_we_state: assert property (@(posedge clk) disable iff (!arst_n)
        ram_we == $past(job_valid && job_ready, 2))
        else begin
            $error("Port A write enable outside the write state");
            fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== dv/tb_conv_pe.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_conv_pe;
    import conv_pkg::*;

    localparam int est_cycles = 5000;            // Longest run is the random batches
    localparam int max_cycles = 4 * est_cycles;

    logic      clk;
    logic      arst_n;
    logic      job_valid;
    conv_job_t job;
    logic      job_ready;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;

    integer      seed = 42473;
    int unsigned cycles = 0;
    kernel_t     m_kernel;   // Model of the kernel registers
    acc_t        m_bias;
    acc_t        m_res [int]; // Model result RAM keyed by address
    bit          touched [int];
    res_addr_t   addr_list [32];

    clk_gen #(.period_ns(8), .rst_cycles(5)) u_clk (.clk(clk), .arst_n(arst_n));

    conv_pe_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .job_valid (job_valid),
        .job       (job),
        .job_ready (job_ready),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    bind conv_pe_top conv_pe_asserts u_asserts (
        .clk(clk), .arst_n(arst_n), .job_valid(job_valid), .job_ready(job_ready),
        .wb_req(wb_req), .wb_rsp(wb_rsp), .ram_we(ram_a_we)
    );

    // Signed dot product of window and kernel on top of a base value
    function automatic acc_t ref_result(input window_t w, input kernel_t k, input acc_t base);
        logic [143:0] wbits;
        logic [143:0] kbits;
        longint       sum;
        wbits = w;
        kbits = k;
        sum   = base;
        for (int n = 0; n < 9; n++) begin
            sum += longint'($signed(wbits[143-16*n -: 16])) *
                   longint'($signed(kbits[143-16*n -: 16]));
        end
        return acc_t'(sum);
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic wb_write(input logic [15:0] adr, input logic [31:0] dat);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        do @(negedge clk); while (!wb_rsp.ack);
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_read(input logic [15:0] adr, output logic [31:0] dat);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
        do @(negedge clk); while (!wb_rsp.ack);
        dat = wb_rsp.dat;
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic send_job(input conv_job_t j);
        @(posedge clk);
        job_valid <= 1'b1;
        job       <= j;
        do @(negedge clk); while (!job_ready);  // Transfer on the next edge
        @(posedge clk);
        job_valid <= 1'b0;
    endtask

    // Updates the model, then hands the job to the DUT
    task automatic run_job(input window_t w, input res_addr_t a, input logic first);
        conv_job_t j;
        acc_t      base;
        j.window   = w;
        j.out_addr = a;
        j.first    = first;
        base       = first ? m_bias : m_res[a];
        m_res[a]   = ref_result(w, m_kernel, base);
        send_job(j);
    endtask

    task automatic rand_144(output logic [143:0] v);
        logic [31:0] r;
        v = '0;
        for (int n = 0; n < 9; n++) begin
            r = $random(seed);
            v = {v[127:0], r[15:0]};
        end
    endtask

    task automatic load_kernel(input logic [143:0] kbits);
        logic [31:0] r;
        for (int n = 0; n < 9; n++) begin
            r = $random(seed);  // Upper half is junk the port must drop
            wb_write(16'(n), {r[31:16], kbits[143-16*n -: 16]});
        end
        m_kernel = kbits;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        st = 32'd1;
        while (st[0]) begin
            wb_read(16'(reg_status), st);
        end
    endtask

    task automatic check_result(input res_addr_t a, input acc_t exp);
        logic [31:0] lo;
        logic [31:0] hi;
        wb_read({1'b1, a, 1'b0}, lo);
        wb_read({1'b1, a, 1'b1}, hi);
        check_val($sformatf("res[%0d].lo", a), lo, exp[31:0]);
        check_val($sformatf("res[%0d].hi", a), hi, {{16{exp[47]}}, exp[47:32]});
    endtask

    task automatic check_kernel_regs();
        logic [31:0]  rd;
        logic [143:0] kbits;
        kbits = m_kernel;
        for (int n = 0; n < 9; n++) begin
            wb_read(16'(n), rd);
            check_val($sformatf("k%0d", n), rd, 32'($signed(kbits[143-16*n -: 16])));
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $fatal(1, "Timeout");
        end
    end

    // Stop at the first bound assertion failure
    always @(posedge clk) begin
        if (u_dut.u_asserts.fail_cnt != 0) begin
            $display("A protocol assertion failed in the bound checker");
            $display("*** FAILED ***");
            $fatal(1, "Assertion failure");
        end
    end

    initial begin
        logic [31:0]  r;
        logic [31:0]  rd;
        logic [143:0] kbits;
        logic [143:0] wbits;
        res_addr_t    a;
        job_valid = 1'b0;
        job       = '0;
        wb_req    = '0;
        @(posedge arst_n);

        // Reset state
        @(negedge clk);
        check_val("job_ready", 32'(job_ready), 32'd1);
        for (int n = 0; n < 12; n++) begin
            wb_read(16'(n), rd);
            check_val($sformatf("reg[%0d]", n), rd, 32'h0);
        end

        // Kernel and bias registers with odd coefficients forced negative
        rand_144(kbits);
        for (int n = 1; n < 9; n += 2) begin
            kbits[143-16*n] = 1'b1;
        end
        load_kernel(kbits);
        check_kernel_regs();
        wb_write(16'(reg_bias_lo), 32'hdead_beef);
        wb_write(16'(reg_bias_hi), 32'h5a5a_f123);
        m_bias = {16'hf123, 32'hdead_beef};
        wb_read(16'(reg_bias_lo), rd);
        check_val("bias_lo", rd, 32'hdead_beef);
        wb_read(16'(reg_bias_hi), rd);
        check_val("bias_hi", rd, 32'hffff_f123);

        // Single job from bias
        rand_144(wbits);
        run_job(wbits, 14'd5, 1'b1);
        wait_idle();
        check_result(14'd5, m_res[5]);

        // Four channels into one output
        for (int i = 0; i < 4; i++) begin
            rand_144(wbits);
            run_job(wbits, 14'd77, i == 0);
        end
        wait_idle();
        check_result(14'd77, m_res[77]);

        // Random batches with a new kernel before each
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            addr_list[i] = r[13:0];
        end
        for (int b = 0; b < 4; b++) begin
            wait_idle();
            rand_144(kbits);
            load_kernel(kbits);
            for (int i = 0; i < 50; i++) begin
                r = $random(seed);
                a = addr_list[r[4:0]];
                rand_144(wbits);
                run_job(wbits, a, !touched.exists(a));
                touched[a] = 1'b1;
                repeat (r[9:8]) @(posedge clk);
            end
        end
        wait_idle();
        for (int i = 0; i < 32; i++) begin
            check_result(addr_list[i], m_res[addr_list[i]]);
        end

        // Holes in the map, aliases and writes to the result region
        wb_write(16'h000c, 32'hffff_ffff);
        wb_write(16'h0013, 32'hffff_ffff);  // Aliases k3 if decode were partial
        wb_write(16'(reg_status), 32'hffff_ffff);
        for (int n = 12; n < 16; n++) begin
            wb_read(16'(n), rd);
            check_val($sformatf("reg[%0d]", n), rd, 32'h0);
        end
        wb_read(16'h0013, rd);
        check_val("reg[0x13]", rd, 32'h0);
        wb_read(16'(reg_status), rd);
        check_val("status", rd, 32'h0);
        check_kernel_regs();
        wb_write({1'b1, 14'd5, 1'b0}, 32'h1234_5678);
        wb_write({1'b1, 14'd5, 1'b1}, 32'h8765_4321);
        check_result(14'd5, m_res[5]);

        if (u_dut.u_asserts.fail_cnt != 0) begin
            $display("%0d assertion failures", u_dut.u_asserts.fail_cnt);
            $display("*** FAILED ***");
            $fatal(1, "Assertion failures");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
source/conv_pkg.sv
source/mac3x3.sv
source/dual_port_ram.sv
source/accum_seq.sv
source/wb_cfg_port.sv
source/conv_pe_top.sv
dv/clk_gen.sv
dv/conv_pe_asserts.sv
dv/tb_conv_pe.sv
